/* Makefile */
# Verilator build and run for the stream_regex testbench
# Any variable can be overridden on the command line

VERILATOR ?= verilator
TOP       ?= stream_regex_tb
FILELIST  ?= stream_regex.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= all tests passed
VFLAGS    ?= --binary --timing --assert -Wno-fatal

# Sources are taken from the file list so a change to any of them rebuilds
SRCS := $(filter %.sv %.v,$(shell cat $(FILELIST)))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# The log decides pass or fail, not the exit code of the binary
run: $(BIN)
	-./$(BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -qx '$(PASS_MSG)' $(LOG) || { echo "Simulation failed, see $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* dv/stream_regex_tb.sv */
module stream_regex_tb;

   localparam int CLK_PERIOD     = 40;
   localparam int RESET_CYCLES   = 16;
   localparam int RAND_PKTS      = 200;
   localparam int DIRECTED_PKTS  = 9;
   // Load, gap per byte for up to 12 bytes, eop and idle
   localparam int MAX_PKT_CYCLES = 32;
   localparam int WATCHDOG_TIME  =
      (RESET_CYCLES + (RAND_PKTS + DIRECTED_PKTS) * MAX_PKT_CYCLES + 100) * CLK_PERIOD;

   logic                                 clk;
   logic                                 rst_n;
   stream_regex_pkg::char_beat_t         beat;
   stream_regex_pkg::pkt_ctl_t           ctl;
   logic [1:0]                           enable;
   logic [stream_regex_pkg::COUNT_W-1:0] count_user;
   logic [stream_regex_pkg::COUNT_W-1:0] count_pass;
   logic [1:0]                           fired;

   int    errors = 0;
   // Letters of both literals plus one filler
   string letters = "USERPAZ";
   string pats [2] = '{"USER", "PASS"};
   // Streams whose saved entry was written at least once in each category
   bit    seen [2][stream_regex_pkg::STREAMS];

   // Reference model with index 0 for USER and 1 for PASS
   logic [stream_regex_pkg::COUNT_W-1:0] exp_count [2];
   logic [1:0]                           exp_fired;
   int                                   m_state [2];
   bit                                   m_accept [2];
   bit                                   m_restore [2];
   int                                   m_restore_val [2];
   int                                   m_saved [2][stream_regex_pkg::STREAMS];

   stream_regex_top dut_i (
      .clk        (clk),
      .rst_n      (rst_n),
      .beat       (beat),
      .ctl        (ctl),
      .enable     (enable),
      .count_user (count_user),
      .count_pass (count_pass),
      .fired      (fired)
   );

   initial
   begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   // Literal automaton step that restarts on a mismatch
   function automatic int next_state(input string pat, input int st, input logic [7:0] b,
                                     output bit hit);
      hit = 1'b0;
      if (b == pat[st])
      begin
         // Last byte completes the literal and wraps to idle
         if (st + 1 == pat.len())
         begin
            hit = 1'b1;
            return 0;
         end
         return st + 1;
      end
      return (b == pat[0]) ? 1 : 0;
   endfunction

   always @(posedge clk)
   begin
      bit hit;
      bit fired_old;
      for (int c = 0; c < 2; c++)
      begin
         if (!rst_n)
         begin
            exp_count[c] = '0;
            exp_fired[c] = 1'b0;
            m_state[c]   = 0;
            m_accept[c]  = 1'b0;
            m_restore[c] = 1'b0;
         end
         else
         begin
            fired_old = exp_fired[c];
            hit = 1'b0;
            // End state kept only for enabled packets
            if (ctl.eop && enable[c])
               m_saved[c][ctl.stream_id] = m_state[c];
            if (m_restore[c])
               m_state[c] = m_restore_val[c];
            else if (beat.vld)
               m_state[c] = next_state(pats[c], m_state[c], beat.data, hit);
            if (ctl.load_state)
               exp_fired[c] = 1'b0;
            if (m_accept[c])
               exp_fired[c] = 1'b1;
            // One count per packet at most
            if (ctl.eop)
            begin
               if (enable[c])
                  exp_count[c] = exp_count[c] + stream_regex_pkg::COUNT_W'(fired_old);
               else
                  exp_fired[c] = 1'b0;
            end
            // Restore lands one cycle after load_state
            m_restore[c] = ctl.load_state;
            if (ctl.load_state)
               m_restore_val[c] = ctl.new_stream ? 0 : m_saved[c][ctl.stream_id];
            m_accept[c] = hit;
         end
      end
   end

   // Model against DUT in every cycle
   count_user_a: assert property (@(posedge clk) disable iff (!rst_n) count_user == exp_count[0])
   else
   begin
      errors++;
      $display("FAIL %0t count_user expected %0d actual %0d", $time,
               $sampled(exp_count[0]), $sampled(count_user));
   end

   count_pass_a: assert property (@(posedge clk) disable iff (!rst_n) count_pass == exp_count[1])
   else
   begin
      errors++;
      $display("FAIL %0t count_pass expected %0d actual %0d", $time,
               $sampled(exp_count[1]), $sampled(count_pass));
   end

   fired_a: assert property (@(posedge clk) disable iff (!rst_n) fired == exp_fired)
   else
   begin
      errors++;
      $display("FAIL %0t fired expected %b actual %b", $time, $sampled(exp_fired),
               $sampled(fired));
   end

   // Counts move only in the cycle after eop
   count_step_a: assert property (@(posedge clk) disable iff (!rst_n)
      ({count_user, count_pass} != $past({count_user, count_pass})) |-> $past(ctl.eop))
   else
   begin
      errors++;
      $display("Count changed at %0t without an eop in the previous cycle", $time);
   end

   // Directed expectations sampled between edges
   task automatic check_outputs(input logic [stream_regex_pkg::COUNT_W-1:0] exp_user,
                                input logic [stream_regex_pkg::COUNT_W-1:0] exp_pass,
                                input logic [1:0] exp_f);
      assert (count_user == exp_user)
      else
      begin
         errors++;
         $display("FAIL %0t count_user expected %0d actual %0d", $time, exp_user, count_user);
      end
      assert (count_pass == exp_pass)
      else
      begin
         errors++;
         $display("FAIL %0t count_pass expected %0d actual %0d", $time, exp_pass, count_pass);
      end
      assert (fired == exp_f)
      else
      begin
         errors++;
         $display("FAIL %0t fired expected %b actual %b", $time, exp_f, fired);
      end
   endtask

   // One packet as load then beats then eop with the minimum spacing
   task automatic send_packet(input int id, input bit new_s, input logic [1:0] en,
                              input string payload, input bit gaps);
      @(negedge clk);
      enable         = en;
      ctl.stream_id  = stream_regex_pkg::ID_W'(id);
      ctl.new_stream = new_s;
      ctl.load_state = 1'b1;
      @(negedge clk);
      ctl.load_state = 1'b0;
      @(negedge clk);
      for (int k = 0; k < payload.len(); k++)
      begin
         // Idle beat with junk data
         if (gaps && $urandom_range(3, 0) == 0)
         begin
            beat.vld  = 1'b0;
            beat.data = letters[$urandom_range(6, 0)];
            @(negedge clk);
         end
         beat.data = payload[k];
         beat.vld  = 1'b1;
         @(negedge clk);
      end
      beat.vld = 1'b0;
      @(negedge clk);
      ctl.eop = 1'b1;
      @(negedge clk);
      ctl.eop = 1'b0;
      @(negedge clk);
      for (int c = 0; c < 2; c++)
      begin
         if (en[c])
            seen[c][id] = 1'b1;
      end
   endtask

   initial
   begin
      int          id;
      int          len;
      logic [1:0]  en;
      bit          new_s;
      string       payload;
      void'($urandom(7));
      rst_n  = 1'b0;
      beat   = '0;
      ctl    = '0;
      enable = '0;
      repeat (RESET_CYCLES) @(posedge clk);
      @(negedge clk);
      rst_n = 1'b1;
      @(negedge clk);
      check_outputs(0, 0, 2'b00);

      // Single and double USER match add one each
      send_packet(1, 1'b1, 2'b11, "ZUSERZ", 1'b0);
      check_outputs(1, 0, 2'b01);
      send_packet(2, 1'b1, 2'b11, "USERUSER", 1'b0);
      check_outputs(2, 0, 2'b01);

      // PASS split over two packets of stream 3
      send_packet(3, 1'b1, 2'b11, "ZPA", 1'b0);
      check_outputs(2, 0, 2'b00);
      send_packet(3, 1'b0, 2'b11, "SSZ", 1'b0);
      check_outputs(2, 1, 2'b10);
      // Same split broken by new_stream
      send_packet(4, 1'b1, 2'b11, "PA", 1'b0);
      send_packet(4, 1'b1, 2'b11, "SS", 1'b0);
      check_outputs(2, 1, 2'b00);

      // Disabled packet matches but neither counts nor saves
      send_packet(5, 1'b1, 2'b11, "PA", 1'b0);
      send_packet(5, 1'b0, 2'b00, "SSUSER", 1'b0);
      check_outputs(2, 1, 2'b00);
      send_packet(5, 1'b0, 2'b11, "SS", 1'b0);
      check_outputs(2, 2, 2'b10);

      // Random interleaving over all streams
      for (int p = 0; p < RAND_PKTS; p++)
      begin
         id    = $urandom_range(stream_regex_pkg::STREAMS - 1, 0);
         en    = 2'($urandom_range(3, 0));
         new_s = !(seen[0][id] && seen[1][id]) || ($urandom_range(7, 0) == 0);
         len   = $urandom_range(12, 1);
         payload = "";
         for (int k = 0; k < len; k++)
            payload = $sformatf("%s%c", payload, letters[$urandom_range(6, 0)]);
         send_packet(id, new_s, en, payload, 1'b1);
      end

      repeat (4) @(negedge clk);
      $display("errors: %0d", errors);
      if (errors == 0)
         $display("all tests passed");
      else
         $display("tests failed");
      $finish;
   end

   // Bound on the whole run
   initial
   begin
      #(WATCHDOG_TIME);
      $display("Timeout, the packet sequence did not complete in time");
      $display("tests failed");
      $finish;
   end

endmodule

/* hdl/literal_matcher.sv */
module literal_matcher #(
   parameter logic [stream_regex_pkg::PAT_LEN*8-1:0] PATTERN = stream_regex_pkg::PAT_USER
) (
   input  logic                                 clk,
   input  logic                                 rst_n,
   input  stream_regex_pkg::char_beat_t         beat,
   input  logic [stream_regex_pkg::STATE_W-1:0] restore_state,
   input  logic                                 restore_vld,
   output logic [stream_regex_pkg::STATE_W-1:0] cur_state,
   output logic                                 accept
);

   // State is the number of pattern bytes matched so far
   logic [stream_regex_pkg::STATE_W-1:0] state;
   logic [stream_regex_pkg::STATE_W-1:0] state_inc;
   logic [stream_regex_pkg::STATE_W-1:0] state_nxt;
   logic [7:0]                           expect_byte;
   logic [7:0]                           first_byte;
   logic                                 byte_hit;
   logic                                 restart_hit;
   logic                                 done;

   // Byte the automaton waits for in the current state
   // Pattern is stored first character high
   assign expect_byte = PATTERN[(stream_regex_pkg::PAT_LEN - 1 - state) * 8 +: 8];
   assign first_byte  = PATTERN[stream_regex_pkg::PAT_LEN*8-1 -: 8];

   assign byte_hit    = (beat.data == expect_byte);
   assign restart_hit = (beat.data == first_byte);
   assign state_inc   = state + 1'b1;

   // Last byte of the literal seen
   assign done = beat.vld && byte_hit && (state_inc == stream_regex_pkg::PAT_LEN);

   // Next state on a valid byte
   always_comb
   begin
      if (byte_hit)
      begin
         // Complete match wraps to idle, literal must not self-overlap
         if (done)
            state_nxt = '0;
         else
            state_nxt = state_inc;
      end
      else if (restart_hit)
      begin
         // Mismatch but the byte can open a new match
         state_nxt = {{(stream_regex_pkg::STATE_W-1){1'b0}}, 1'b1};
      end
      else
      begin
         state_nxt = '0;
      end
   end

   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         state  <= '0;
         accept <= 1'b0;
      end
      else
      begin
         // One-cycle pulse after the completing beat
         accept <= done;

         // Restore from the stream store wins over a beat
         if (restore_vld)
            state <= restore_state;
         else if (beat.vld)
            state <= state_nxt;
      end
   end

   // Store samples this on the eop edge
   assign cur_state = state;

endmodule

/* hdl/match_category.sv */
module match_category #(
   parameter logic [stream_regex_pkg::PAT_LEN*8-1:0] PATTERN = stream_regex_pkg::PAT_USER
) (
   input  logic                                 clk,
   input  logic                                 rst_n,
   input  stream_regex_pkg::char_beat_t         beat,
   input  stream_regex_pkg::pkt_ctl_t           ctl,
   input  logic                                 enable,
   output logic [stream_regex_pkg::COUNT_W-1:0] count,
   output logic                                 fired
);

   logic [stream_regex_pkg::STATE_W-1:0] restore_state;
   logic                                 restore_vld;
   logic [stream_regex_pkg::STATE_W-1:0] cur_state;
   logic                                 accept;
   logic                                 save;
   logic [stream_regex_pkg::COUNT_W-1:0] fired_ext;

   // Only enabled packets commit their end state
   assign save = ctl.eop & enable;

   // At most one count per packet however many matches
   assign fired_ext = {{(stream_regex_pkg::COUNT_W-1){1'b0}}, fired};

   // Per-stream state save and restore
   stream_state_store store_i (
      .clk           (clk),
      .rst_n         (rst_n),
      .ctl           (ctl),
      .save          (save),
      .cur_state     (cur_state),
      .restore_state (restore_state),
      .restore_vld   (restore_vld)
   );

   // Byte-serial automaton for this category's literal
   literal_matcher #(
      .PATTERN (PATTERN)
   ) matcher_i (
      .clk           (clk),
      .rst_n         (rst_n),
      .beat          (beat),
      .restore_state (restore_state),
      .restore_vld   (restore_vld),
      .cur_state     (cur_state),
      .accept        (accept)
   );

   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         fired <= 1'b0;
         count <= '0;
      end
      else
      begin
         // Speculative flag restarts with every packet
         if (ctl.load_state)
            fired <= 1'b0;

         // Any match in the packet sets it
         if (accept)
            fired <= 1'b1;

         // Finalize at end of packet
         if (ctl.eop)
         begin
            if (enable)
               count <= count + fired_ext;   // fired kept until next load
            else
               fired <= 1'b0;
         end
      end
   end

endmodule

/* hdl/stream_regex_pkg.sv */
package stream_regex_pkg;

   // Number of interleaved streams tracked per category
   localparam int STREAMS = 64;

   // Stream id width, covers all STREAMS entries
   localparam int ID_W = 6;

   // Automaton state width
   // Holds patterns of up to 7 bytes
   localparam int STATE_W = 3;

   // Per-category match count width
   localparam int COUNT_W = 16;

   // Pattern length in bytes, typed to compare directly with state
   localparam logic [STATE_W-1:0] PAT_LEN = STATE_W'(4);

   // Literal patterns, first character in the top byte
   localparam logic [PAT_LEN*8-1:0] PAT_USER = "USER";
   localparam logic [PAT_LEN*8-1:0] PAT_PASS = "PASS";

   // One byte of payload with its strobe
   typedef struct packed {
      logic [7:0] data;
      logic       vld;
   } char_beat_t;

   // Per-packet control
   // stream_id and new_stream held from load_state through eop
   typedef struct packed {
      logic [ID_W-1:0] stream_id;
      logic            new_stream;
      logic            load_state;
      logic            eop;
   } pkt_ctl_t;

endpackage

/* hdl/stream_regex_top.sv */
module stream_regex_top (
   input  logic                                 clk,
   input  logic                                 rst_n,
   input  stream_regex_pkg::char_beat_t         beat,
   input  stream_regex_pkg::pkt_ctl_t           ctl,
   input  logic [1:0]                           enable,
   output logic [stream_regex_pkg::COUNT_W-1:0] count_user,
   output logic [stream_regex_pkg::COUNT_W-1:0] count_pass,
   output logic [1:0]                           fired
);

   // Both categories see the same byte stream and packet control
   // Bit 0 of enable and fired is the USER category
   // Bit 1 is the PASS category

   // USER literal
   match_category #(
      .PATTERN (stream_regex_pkg::PAT_USER)
   ) cat_user_i (
      .clk    (clk),
      .rst_n  (rst_n),
      .beat   (beat),
      .ctl    (ctl),
      .enable (enable[0]),
      .count  (count_user),
      .fired  (fired[0])
   );

   // PASS literal
   // Its state memory is separate, so streams resume per category
   match_category #(
      .PATTERN (stream_regex_pkg::PAT_PASS)
   ) cat_pass_i (
      .clk    (clk),
      .rst_n  (rst_n),
      .beat   (beat),
      .ctl    (ctl),
      .enable (enable[1]),
      .count  (count_pass),
      .fired  (fired[1])
   );

endmodule

/* hdl/stream_state_store.sv */
module stream_state_store (
   input  logic                                 clk,
   input  logic                                 rst_n,
   input  stream_regex_pkg::pkt_ctl_t           ctl,
   input  logic                                 save,
   input  logic [stream_regex_pkg::STATE_W-1:0] cur_state,
   output logic [stream_regex_pkg::STATE_W-1:0] restore_state,
   output logic                                 restore_vld
);

   // One saved automaton state per stream
   logic [stream_regex_pkg::STATE_W-1:0] state_mem [stream_regex_pkg::STREAMS];

   // Save at end of packet
   // Category already folded the enable into save
   always_ff @(posedge clk)
   begin
      if (save)
         state_mem[ctl.stream_id] <= cur_state;
   end

   // Restore data, captured only at packet start
   always_ff @(posedge clk)
   begin
      if (ctl.load_state)
      begin
         // New stream starts from idle, else resume saved state
         if (ctl.new_stream)
            restore_state <= '0;
         else
            restore_state <= state_mem[ctl.stream_id];
      end
   end

   // Load strobe to the matcher, one cycle after load_state
   always_ff @(posedge clk)
   begin
      if (!rst_n)
         restore_vld <= 1'b0;
      else
         restore_vld <= ctl.load_state;
   end

endmodule

/* stream_regex.f */
hdl/stream_regex_pkg.sv
hdl/literal_matcher.sv
hdl/stream_state_store.sv
hdl/match_category.sv
hdl/stream_regex_top.sv
dv/stream_regex_tb.sv
